/* logic/nanov_consts.svh */
////////////////////
// Widths and major opcode values shared by the serial datapath.
// Include in any file that needs a width or an opcode value.
////////////////////
`ifndef NANOV_CONSTS_SVH
`define NANOV_CONSTS_SVH

// Data width and register file size for RV32E.
`define NANOV_XLEN 32
`define NANOV_NUM_REGS 16

// Major opcodes, instruction bits 6 to 2.
`define NANOV_OPC_OP_IMM 5'b00100
`define NANOV_OPC_OP 5'b01100
`define NANOV_OPC_STORE 5'b01000

`endif

/* logic/nanov_isa_pkg.sv */
////////////////////
// Instruction field types for the decoder and the core ports.
////////////////////
`include "nanov_consts.svh"

package nanov_isa_pkg;

    // Full instruction word, always 32 bits whatever the data width.
    typedef logic [31:0] instr_t;

    // Major opcode, instruction bits 6 to 2.
    typedef logic [4:0] opcode_t;

    // Register index into the RV32E register file.
    typedef logic [$clog2(`NANOV_NUM_REGS)-1:0] reg_idx_t;

    typedef logic [2:0] funct3_t;

    // ALU operation: modifier bit above funct3.
    // The modifier selects SUB and SRA/SRAI.
    typedef logic [3:0] alu_op_t;

endpackage

/* logic/nanov_core_pkg.sv */
////////////////////
// Types of the bit-serial datapath: data word, bit position, pass number.
////////////////////
`include "nanov_consts.svh"

package nanov_core_pkg;

    typedef logic [`NANOV_XLEN-1:0] word_t;

    // Position of the current bit within a pass.
    typedef logic [$clog2(`NANOV_XLEN)-1:0] bit_idx_t;

    // Pass number supplied with the instruction.
    typedef logic [1:0] pass_t;

    typedef logic [$clog2(`NANOV_XLEN)-1:0] shamt_t;

endpackage

/* logic/nanov_decode.sv */
////////////////////
// Bit index counter and instruction decode.
// Produces register fields, the serial immediate and per-clock strobes.
////////////////////
`timescale 1ns/100ps
`include "nanov_consts.svh"

module nanov_decode (
    input  logic                     clk,
    input  logic                     rstn,
    input  nanov_isa_pkg::instr_t    instr,
    input  nanov_core_pkg::pass_t    cycle,
    output nanov_core_pkg::bit_idx_t bit_idx,
    output nanov_isa_pkg::reg_idx_t  rs1,
    output nanov_isa_pkg::reg_idx_t  rs2,
    output nanov_isa_pkg::reg_idx_t  rd,
    output nanov_isa_pkg::alu_op_t   alu_op,
    output logic                     sel_rs2,
    output logic                     imm_bit,
    output nanov_core_pkg::shamt_t   imm_shamt,
    output logic                     wr_en,
    output logic                     cmp_last,
    output logic                     capture_shift,
    output logic                     capture_store
);

    nanov_isa_pkg::opcode_t  opcode;
    nanov_isa_pkg::funct3_t  funct3;
    nanov_core_pkg::word_t   i_imm;
    logic                    running;
    logic                    is_op;
    logic                    is_alu;
    logic                    is_store;
    logic                    is_shift;
    logic                    is_cmp;
    logic                    first_pass;

    // Index holds at 0 for the first clock after reset release.
    always_ff @(posedge clk) begin
        if (!rstn) begin
            running <= 1'b0;
            bit_idx <= '0;
        end else begin
            running <= 1'b1;
            if (running) begin
                bit_idx <= bit_idx + 1'b1;
            end
        end
    end

    assign opcode = instr[6:2];
    assign funct3 = instr[14:12];

    assign rs1 = instr[18:15];
    assign rs2 = instr[23:20];
    assign rd  = instr[10:7];

    assign is_op    = (opcode == `NANOV_OPC_OP);
    assign is_alu   = is_op || (opcode == `NANOV_OPC_OP_IMM);
    assign is_store = (opcode == `NANOV_OPC_STORE);
    assign is_shift = is_alu && (funct3[1:0] == 2'b01);
    assign is_cmp   = is_alu && (funct3[2:1] == 2'b01);

    // Bit 30 also marks SRAI, so it is kept for right shifts of either form.
    assign alu_op  = {instr[30] && (is_op || funct3 == 3'b101), funct3};
    assign sel_rs2 = is_op;

    assign i_imm     = {{(`NANOV_XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_bit   = i_imm[bit_idx];
    assign imm_shamt = instr[24:20];

    assign first_pass = running && (cycle == 2'd0);

    // Shifts write on their second pass, everything else on the first.
    assign wr_en = running && is_alu && (cycle == (is_shift ? 2'd1 : 2'd0));

    assign cmp_last = first_pass && is_cmp && (bit_idx == '1);

    assign capture_shift = first_pass && is_shift && (bit_idx < 5);

    assign capture_store = (first_pass && is_shift) || (running && is_store);

endmodule

/* logic/nanov_registers.sv */
////////////////////
// Serial register file, one circular shift register per entry.
// All entries rotate every clock; x0 has no storage and reads as zero.
////////////////////
`timescale 1ns/100ps
`include "nanov_consts.svh"

module nanov_registers (
    input  logic                    clk,
    input  logic                    rstn,
    input  nanov_isa_pkg::reg_idx_t rs1,
    input  nanov_isa_pkg::reg_idx_t rs2,
    input  nanov_isa_pkg::reg_idx_t rd,
    input  logic                    wr_en,
    input  logic                    cmp_last,
    input  logic                    rd_bit,
    input  logic                    cmp_bit,
    output logic                    rs1_bit,
    output logic                    rs2_bit
);

    nanov_core_pkg::word_t       regs [1:`NANOV_NUM_REGS-1];
    logic [`NANOV_NUM_REGS-1:0]  low_bits;

    assign low_bits[0] = 1'b0;

    for (genvar i = 1; i < `NANOV_NUM_REGS; i++) begin : g_reg
        logic wr_hit;
        logic cmp_hit;
        logic top_bit;
        logic next_low;

        assign wr_hit  = rstn && wr_en && (rd == nanov_isa_pkg::reg_idx_t'(i));
        assign cmp_hit = rstn && cmp_last && (rd == nanov_isa_pkg::reg_idx_t'(i));

        // Unwritten bits rotate back in at the top.
        assign top_bit = wr_hit ? rd_bit : regs[i][0];

        // Bit 1 moves to bit 0 on this edge, so the flag goes there.
        assign next_low = cmp_hit ? cmp_bit : regs[i][1];

        always_ff @(posedge clk) begin
            regs[i] <= {top_bit, regs[i][`NANOV_XLEN-1:2], next_low};
        end

        assign low_bits[i] = regs[i][0];
    end

    assign rs1_bit = low_bits[rs1];
    assign rs2_bit = low_bits[rs2];

endmodule

/* logic/nanov_execute.sv */
////////////////////
// Serial adder and logic unit, compare flag, and the serial shifter.
// The shifter reads its source word from the store buffer.
////////////////////
`timescale 1ns/100ps
`include "nanov_consts.svh"

module nanov_execute (
    input  logic                     clk,
    input  logic                     rstn,
    input  nanov_core_pkg::bit_idx_t bit_idx,
    input  nanov_isa_pkg::alu_op_t   alu_op,
    input  logic                     sel_rs2,
    input  logic                     imm_bit,
    input  nanov_core_pkg::shamt_t   imm_shamt,
    input  logic                     capture_shift,
    input  logic                     rs1_bit,
    input  logic                     rs2_bit,
    input  nanov_core_pkg::word_t    store_word,
    output logic                     alu_bit,
    output logic                     shift_bit,
    output logic                     cmp_flag
);

    localparam int IDX_W = $bits(nanov_core_pkg::bit_idx_t);
    localparam int SH_W  = $bits(nanov_core_pkg::shamt_t);

    nanov_isa_pkg::funct3_t  funct3;
    nanov_core_pkg::shamt_t  shamt_q;
    nanov_core_pkg::shamt_t  shamt;
    logic [IDX_W:0]          src_pos;
    logic                    is_sub;
    logic                    is_cmp;
    logic                    invert_b;
    logic                    b_bit;
    logic                    b_eff;
    logic                    carry_q;
    logic                    carry_in;
    logic                    sum_bit;
    logic                    carry_out;
    logic                    lt_signed;
    logic                    shift_right;
    logic                    fill_bit;

    assign funct3 = alu_op[2:0];

    assign is_sub   = alu_op[3] && (funct3 == 3'b000);
    assign is_cmp   = (funct3[2:1] == 2'b01);
    assign invert_b = is_sub || is_cmp;

    assign b_bit = sel_rs2 ? rs2_bit : imm_bit;
    assign b_eff = b_bit ^ invert_b;

    // Subtraction is a + ~b + 1, the +1 preset at bit 0.
    assign carry_in  = (bit_idx == '0) ? invert_b : carry_q;
    assign sum_bit   = rs1_bit ^ b_eff ^ carry_in;
    assign carry_out = (rs1_bit & b_eff) | (rs1_bit & carry_in) | (b_eff & carry_in);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            carry_q <= 1'b0;
        end else begin
            carry_q <= carry_out;
        end
    end

    always_comb begin
        case (funct3)
            3'b100:  alu_bit = rs1_bit ^ b_bit;
            3'b110:  alu_bit = rs1_bit | b_bit;
            3'b111:  alu_bit = rs1_bit & b_bit;
            default: alu_bit = sum_bit;
        endcase
    end

    // Meaningful at the top bit only.
    // Signs differ: a is less if negative; otherwise the sign of a - b.
    assign lt_signed = (rs1_bit ^ b_bit) ? rs1_bit : sum_bit;
    assign cmp_flag  = funct3[0] ? ~carry_out : lt_signed;

    // rs2 arrives low bit first over bits 0 to 4.
    always_ff @(posedge clk) begin
        if (capture_shift) begin
            shamt_q <= {rs2_bit, shamt_q[SH_W-1:1]};
        end
    end

    assign shamt       = sel_rs2 ? shamt_q : imm_shamt;
    assign shift_right = funct3[2];

    // Extra top bit flags a position outside the word.
    assign src_pos = shift_right ? ({1'b0, bit_idx} + {1'b0, shamt}) :
                                   ({1'b0, bit_idx} - {1'b0, shamt});

    assign fill_bit  = alu_op[3] && store_word[`NANOV_XLEN-1];
    assign shift_bit = src_pos[IDX_W] ? fill_bit : store_word[src_pos[IDX_W-1:0]];

endmodule

/* logic/nanov_result.sv */
////////////////////
// Store buffer, destination bit select and compare outputs.
////////////////////
`timescale 1ns/100ps
`include "nanov_consts.svh"

module nanov_result (
    input  logic                   clk,
    input  logic                   rstn,
    input  nanov_isa_pkg::alu_op_t alu_op,
    input  logic                   capture_store,
    input  logic                   rs1_bit,
    input  logic                   rs2_bit,
    input  logic                   alu_bit,
    input  logic                   shift_bit,
    input  logic                   cmp_flag,
    input  logic                   cmp_last,
    output logic                   rd_bit,
    output logic                   cmp_bit,
    output nanov_core_pkg::word_t  store_word,
    output nanov_core_pkg::word_t  data_out,
    output logic                   branch
);

    nanov_core_pkg::word_t store_q;
    logic                  is_shift;
    logic                  is_cmp;
    logic                  store_in;

    assign is_shift = (alu_op[1:0] == 2'b01);
    assign is_cmp   = (alu_op[2:1] == 2'b01);

    // Shifts buffer their source, stores buffer rs2.
    assign store_in = is_shift ? rs1_bit : rs2_bit;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            store_q <= '0;
        end else if (capture_store) begin
            store_q <= {store_in, store_q[`NANOV_XLEN-1:1]};
        end
    end

    assign store_word = store_q;
    assign data_out   = store_q;

    // Compares write zeros; the flag lands in bit 0 at the end.
    assign rd_bit = is_shift ? shift_bit : (is_cmp ? 1'b0 : alu_bit);

    assign cmp_bit = cmp_last && cmp_flag;
    assign branch  = cmp_last && cmp_flag;

endmodule

/* logic/nanov_core.sv */
////////////////////
// Top level of the bit-serial RV32E datapath.
// Hold instr and cycle stable for each 32-clock pass.
////////////////////
`timescale 1ns/100ps

module nanov_core (
    input  logic                  clk,
    input  logic                  rstn,
    input  nanov_isa_pkg::instr_t instr,
    input  nanov_core_pkg::pass_t cycle,
    output nanov_core_pkg::word_t data_out,
    output logic                  branch
);

    nanov_core_pkg::bit_idx_t bit_idx;
    nanov_isa_pkg::reg_idx_t  rs1;
    nanov_isa_pkg::reg_idx_t  rs2;
    nanov_isa_pkg::reg_idx_t  rd;
    nanov_isa_pkg::alu_op_t   alu_op;
    nanov_core_pkg::shamt_t   imm_shamt;
    nanov_core_pkg::word_t    store_word;
    logic                     sel_rs2;
    logic                     imm_bit;
    logic                     wr_en;
    logic                     cmp_last;
    logic                     capture_shift;
    logic                     capture_store;
    logic                     rs1_bit;
    logic                     rs2_bit;
    logic                     rd_bit;
    logic                     cmp_bit;
    logic                     alu_bit;
    logic                     shift_bit;
    logic                     cmp_flag;

    nanov_decode decode_i (
        .clk           (clk),
        .rstn          (rstn),
        .instr         (instr),
        .cycle         (cycle),
        .bit_idx       (bit_idx),
        .rs1           (rs1),
        .rs2           (rs2),
        .rd            (rd),
        .alu_op        (alu_op),
        .sel_rs2       (sel_rs2),
        .imm_bit       (imm_bit),
        .imm_shamt     (imm_shamt),
        .wr_en         (wr_en),
        .cmp_last      (cmp_last),
        .capture_shift (capture_shift),
        .capture_store (capture_store)
    );

    nanov_registers registers_i (
        .clk      (clk),
        .rstn     (rstn),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .wr_en    (wr_en),
        .cmp_last (cmp_last),
        .rd_bit   (rd_bit),
        .cmp_bit  (cmp_bit),
        .rs1_bit  (rs1_bit),
        .rs2_bit  (rs2_bit)
    );

    nanov_execute execute_i (
        .clk           (clk),
        .rstn          (rstn),
        .bit_idx       (bit_idx),
        .alu_op        (alu_op),
        .sel_rs2       (sel_rs2),
        .imm_bit       (imm_bit),
        .imm_shamt     (imm_shamt),
        .capture_shift (capture_shift),
        .rs1_bit       (rs1_bit),
        .rs2_bit       (rs2_bit),
        .store_word    (store_word),
        .alu_bit       (alu_bit),
        .shift_bit     (shift_bit),
        .cmp_flag      (cmp_flag)
    );

    nanov_result result_i (
        .clk           (clk),
        .rstn          (rstn),
        .alu_op        (alu_op),
        .capture_store (capture_store),
        .rs1_bit       (rs1_bit),
        .rs2_bit       (rs2_bit),
        .alu_bit       (alu_bit),
        .shift_bit     (shift_bit),
        .cmp_flag      (cmp_flag),
        .cmp_last      (cmp_last),
        .rd_bit        (rd_bit),
        .cmp_bit       (cmp_bit),
        .store_word    (store_word),
        .data_out      (data_out),
        .branch        (branch)
    );

endmodule

/* sim/nanov_core_props.sv */
////////////////////
// Assertions on pass timing and reset values, bound into the core.
////////////////////
`timescale 1ns/100ps

module nanov_core_props (
    input logic                     clk,
    input logic                     rstn,
    input nanov_core_pkg::bit_idx_t bit_idx,
    input nanov_core_pkg::word_t    data_out,
    input logic                     branch,
    input logic                     wr_en,
    input logic                     cmp_last,
    input logic                     capture_shift,
    input logic                     capture_store
);

    int fail_count = 0;

    // Every pass is exactly 32 clocks long.
    wrap_a: assert property (@(posedge clk) disable iff (!rstn)
        bit_idx == 5'd31 |=> bit_idx == 5'd0)
        else begin
            fail_count++;
            $error("bit_idx did not wrap from 31 to 0");
        end

    branch_a: assert property (@(posedge clk) disable iff (!rstn)
        bit_idx != 5'd31 |-> !branch)
        else begin
            fail_count++;
            $error("branch is high outside clock 31");
        end

    // One clock into reset the strobes and outputs are clear.
    reset_a: assert property (@(posedge clk)
        !rstn |=> !(wr_en || cmp_last || capture_shift || capture_store) &&
                  data_out == '0 && !branch)
        else begin
            fail_count++;
            $error("strobe or output not clear during reset");
        end

endmodule

/* sim/nanov_core_tb.sv */
////////////////////
// Testbench for the serial datapath: runs an instruction table in passes
// and checks data_out and branch against a reference model.
////////////////////
`timescale 1ns/100ps
`include "nanov_consts.svh"

module nanov_core_tb;

    localparam int CLK_PERIOD  = 100;
    localparam int DRIVE_DELAY = 5;
    localparam int PASS_CLOCKS = `NANOV_XLEN;

    // What a row checks once its passes are done.
    localparam int CHECK_NONE   = 0;
    localparam int CHECK_STORE  = 1;
    localparam int CHECK_BRANCH = 2;

    typedef struct packed {
        logic [31:0] instr;
        int          passes;
        int          check;
        logic [31:0] expected;
    } row_t;

    logic                  clk;
    logic                  rstn;
    nanov_isa_pkg::instr_t instr;
    nanov_core_pkg::pass_t cycle;
    nanov_core_pkg::word_t data_out;
    logic                  branch;

    row_t        rows[$];
    logic [31:0] model[`NANOV_NUM_REGS];
    int          total_passes;
    bit          table_ready;

    nanov_core dut_i (
        .clk      (clk),
        .rstn     (rstn),
        .instr    (instr),
        .cycle    (cycle),
        .data_out (data_out),
        .branch   (branch)
    );

    bind nanov_core nanov_core_props props_i (
        .clk           (clk),
        .rstn          (rstn),
        .bit_idx       (bit_idx),
        .data_out      (data_out),
        .branch        (branch),
        .wr_en         (wr_en),
        .cmp_last      (cmp_last),
        .capture_shift (capture_shift),
        .capture_store (capture_store)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(string name, logic [31:0] got, logic [31:0] expected);
        if (got !== expected) begin
            $display("Mismatch at %0t ns: %s got 0x%08h, expected 0x%08h",
                     $time, name, got, expected);
            $display("Test failures found");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    // RV32I semantics of the OP and OP-IMM functions.
    function automatic logic [31:0] reference_result(logic [2:0] f3, logic alt,
                                                     logic [31:0] a, logic [31:0] b);
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        sa = a;
        sb = b;
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'd0, sa < sb};
            3'b011:  return {31'd0, a < b};
            3'b100:  return a ^ b;
            3'b101: begin
                if (alt) begin
                    return sa >>> b[4:0];
                end else begin
                    return a >> b[4:0];
                end
            end
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // Immediate shifts carry alt in imm[10] as well.
    function automatic void alu_row(bit use_reg, logic alt, logic [2:0] f3, logic [3:0] rd,
                                    logic [3:0] rs1, logic [3:0] rs2, logic [11:0] imm);
        row_t        row;
        logic [31:0] b;
        b = use_reg ? model[rs2] : {{20{imm[11]}}, imm};
        row.instr = use_reg ? {1'b0, alt, 5'd0, 1'b0, rs2, 1'b0, rs1, f3, 1'b0, rd, 7'b0110011}
                            : {imm, 1'b0, rs1, f3, 1'b0, rd, 7'b0010011};
        row.expected = reference_result(f3, alt, model[rs1], b);
        row.passes = (f3[1:0] == 2'b01) ? 2 : 1;
        row.check = (f3[2:1] == 2'b01) ? CHECK_BRANCH : CHECK_NONE;
        rows.push_back(row);
        if (rd != 4'd0) begin
            model[rd] = row.expected;
        end
    endfunction

    function automatic void store_row(logic [3:0] rs2);
        row_t row;
        row.instr = {7'd0, 1'b0, rs2, 5'd0, 3'b010, 5'd0, 7'b0100011};
        row.passes = 1;
        row.check = CHECK_STORE;
        row.expected = model[rs2];
        rows.push_back(row);
    endfunction

    function automatic logic [3:0] nonzero_reg();
        return 4'(1 + $urandom % 15);
    endfunction

    task automatic build_table();
        logic [3:0] rd;
        logic [3:0] rs1;
        logic [2:0] f3;
        logic       alt;
        model[0] = '0;
        for (int r = 1; r < `NANOV_NUM_REGS; r++) begin
            alu_row(1'b0, 1'b0, 3'b000, 4'(r), 4'd0, 4'd0,
                    (r == 1) ? 12'h7ff : (r == 2) ? 12'h800 : 12'($urandom));
            store_row(4'(r));
        end
        for (int n = 0; n < 24; n++) begin
            rd = nonzero_reg();
            rs1 = 4'($urandom);
            case (n % 6)
                0: alu_row(1'b1, 1'b0, 3'b000, rd, rs1, 4'($urandom), 12'd0);
                1: alu_row(1'b1, 1'b1, 3'b000, rd, rs1, 4'($urandom), 12'd0);
                2: alu_row(1'b1, 1'b0, 3'b100, rd, rs1, 4'($urandom), 12'd0);
                3: alu_row(1'b1, 1'b0, 3'b110, rd, rs1, 4'($urandom), 12'd0);
                4: alu_row(1'b1, 1'b0, 3'b111, rd, rs1, 4'($urandom), 12'd0);
                default: alu_row(1'b0, 1'b0, 3'b000, rd, rs1, 4'd0, 12'($urandom));
            endcase
            store_row(rd);
        end
        // Amounts 0 to 31 rotate over SLL, SRL and SRA in both forms.
        for (int amt = 0; amt < 32; amt++) begin
            f3 = (amt % 3 == 0) ? 3'b001 : 3'b101;
            alt = (amt % 3 == 2);
            rd = nonzero_reg();
            alu_row(1'b0, alt, f3, rd, nonzero_reg(), 4'd0, {1'b0, alt, 5'd0, 5'(amt)});
            store_row(rd);
            alu_row(1'b0, 1'b0, 3'b000, 4'd12, 4'd0, 4'd0, {7'($urandom), 5'(amt)});
            rd = nonzero_reg();
            alu_row(1'b1, alt, f3, rd, nonzero_reg(), 4'd12, 12'd0);
            store_row(rd);
        end
        for (int n = 0; n < 16; n++) begin
            rd = nonzero_reg();
            rs1 = 4'($urandom);
            alu_row(n % 4 < 2, 1'b0, (n % 2 == 0) ? 3'b010 : 3'b011, rd, rs1,
                    (n < 2) ? rs1 : 4'($urandom), 12'($urandom));
            store_row(rd);
        end
        alu_row(1'b0, 1'b0, 3'b000, 4'd0, 4'd1, 4'd0, 12'h123);
        alu_row(1'b1, 1'b0, 3'b110, 4'd0, 4'd1, 4'd2, 12'd0);
        alu_row(1'b1, 1'b0, 3'b011, 4'd0, 4'd1, 4'd2, 12'd0);
        store_row(4'd0);
        total_passes = 0;
        foreach (rows[i]) begin
            total_passes += rows[i].passes;
        end
    endtask

    initial begin : run
        logic expected_branch;
        rstn = 1'b0;
        instr = '0;
        cycle = '0;
        table_ready = 1'b0;
        void'($urandom(97));
        build_table();
        table_ready = 1'b1;
        repeat (5) @(posedge clk);
        #DRIVE_DELAY;
        rstn = 1'b1;
        check_value("data_out", data_out, 32'd0);
        check_value("branch", {31'd0, branch}, 32'd0);
        // This edge leaves bit_idx at 0 and opens the first pass.
        @(posedge clk);
        #DRIVE_DELAY;
        foreach (rows[i]) begin
            for (int p = 0; p < rows[i].passes; p++) begin
                instr = rows[i].instr;
                cycle = nanov_core_pkg::pass_t'(p);
                expected_branch = (rows[i].check == CHECK_BRANCH) && rows[i].expected[0];
                repeat (PASS_CLOCKS - 1) @(posedge clk);
                #DRIVE_DELAY;
                check_value("branch", {31'd0, branch}, {31'd0, expected_branch});
                @(posedge clk);
                #DRIVE_DELAY;
            end
            if (rows[i].check == CHECK_STORE) begin
                check_value("data_out", data_out, rows[i].expected);
            end
        end
        instr = '0;
        if (dut_i.props_i.fail_count != 0) begin
            $display("Test failures found");
            $fatal(1, "Bound assertions reported errors");
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

    initial begin : assertion_watch
        wait (dut_i.props_i.fail_count != 0);
        $display("A bound assertion on the DUT failed");
        $display("Test failures found");
        $fatal(1, "Stopping on assertion failure");
    end

    initial begin : watchdog
        wait (table_ready);
        #((total_passes * PASS_CLOCKS + 20) * CLK_PERIOD);
        $display("Timeout: the instruction table did not finish in the expected time");
        $display("Test failures found");
        $fatal(1, "Watchdog expired");
    end

endmodule

/* filelist.f */
+incdir+logic
logic/nanov_isa_pkg.sv
logic/nanov_core_pkg.sv
logic/nanov_decode.sv
logic/nanov_registers.sv
logic/nanov_execute.sv
logic/nanov_result.sv
logic/nanov_core.sv
sim/nanov_core_props.sv
sim/nanov_core_tb.sv
